//--- design/box_macros.svh
`ifndef BOX_MACROS_SVH
`define BOX_MACROS_SVH

// Window radius and side.
`define BOX_RADIUS 6
`define BOX_WIN 13

// Pixel width in bits.
`define BOX_PIX_W 8

// Largest image side, also the depth of each row memory.
`define BOX_MAX_IMG 64

// Cycles from the completing pixel to its output.
`define BOX_LATENCY 6

`endif

//--- design/box_pkg.sv
`include "box_macros.svh"

package box_pkg;

  // One grayscale pixel.
  typedef logic [`BOX_PIX_W-1:0] pix_t;

  // Row or column index, or image side.
  typedef logic [9:0] coord_t;

  // Sum of one 13-pixel column.
  typedef logic [11:0] col_sum_t;

  // Sum of the full 13x13 window, max 43095.
  typedef logic [15:0] win_sum_t;

  // Thirteen column pixels, oldest row in the low bits.
  typedef logic [`BOX_WIN*`BOX_PIX_W-1:0] col_vec_t;

  typedef enum logic [1:0] {
    IDLE,
    FILL,
    RUN,
    FLUSH
  } ctrl_state_t;

endpackage

//--- design/box_line_window.sv
`include "box_macros.svh"

module box_line_window (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_accept,
  input  logic              i_valid,
  input  box_pkg::pix_t     i_pixel,
  input  box_pkg::coord_t   i_col,
  output logic              o_col_valid,
  output box_pkg::col_vec_t o_column
);

  localparam int ROWS = `BOX_WIN - 1;
  localparam int AW = $clog2(`BOX_MAX_IMG);
  localparam int PW = `BOX_PIX_W;

  // Memory k holds the row that is ROWS-k rows above the current one.
  box_pkg::pix_t row_mem [ROWS][`BOX_MAX_IMG];

  logic              accept_pix;
  logic [AW-1:0]     addr;
  box_pkg::col_vec_t col_next;

  assign accept_pix = i_accept & i_valid;
  assign addr = i_col[AW-1:0];

  // Oldest row at the top, new pixel at the bottom.
  always_comb begin
    for (int k = 0; k < ROWS; k++) begin
      col_next[k*PW +: PW] = row_mem[k][addr];
    end
    col_next[ROWS*PW +: PW] = i_pixel;
  end

  // Every stored row moves up by one at this column.
  always_ff @(posedge clk) begin
    if (accept_pix) begin
      for (int k = 0; k < ROWS - 1; k++) begin
        row_mem[k][addr] <= row_mem[k+1][addr];
      end
      row_mem[ROWS-1][addr] <= i_pixel;
    end
  end

  always_ff @(posedge clk) begin
    if (accept_pix) begin
      o_column <= col_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_col_valid <= 1'b0;
    end else begin
      o_col_valid <= accept_pix;
    end
  end

  a_col_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    accept_pix |-> i_col < `BOX_MAX_IMG);

endmodule

//--- design/box_window_sum.sv
`include "box_macros.svh"

module box_window_sum #(
  parameter int USE_CENTER = 1
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_clear,
  input  logic              i_accept,
  input  logic              i_valid,
  input  box_pkg::coord_t   i_img_size,
  input  logic              i_col_valid,
  input  box_pkg::col_vec_t i_column,
  output box_pkg::coord_t   o_col,
  output logic              o_rows_filled,
  output logic              o_frame_end,
  output logic              o_valid,
  output box_pkg::win_sum_t o_sum,
  output box_pkg::pix_t     o_center
);

  localparam int PW = `BOX_PIX_W;
  localparam int WIN = `BOX_WIN;

  logic            accept_pix;
  box_pkg::coord_t col_cnt;
  box_pkg::coord_t row_cnt;
  box_pkg::coord_t size_m1;
  logic            col_last;
  logic            row_last;

  logic            first_s0;
  logic            sub_s0;
  logic            tag_s0;
  logic [4:1]      v_sr, first_sr, sub_sr, tag_sr;

  box_pkg::pix_t     px [WIN];
  logic [PW:0]       pair_s1 [6];
  box_pkg::pix_t     odd_s1;
  logic [PW+1:0]     quad_s2 [3];
  box_pkg::pix_t     odd_s2;
  logic [PW+2:0]     half_s3 [2];
  box_pkg::col_sum_t col_s4;

  box_pkg::col_sum_t hist [WIN];
  box_pkg::win_sum_t col_ext;
  box_pkg::win_sum_t old_ext;
  box_pkg::win_sum_t acc_sum;

  assign accept_pix = i_accept & i_valid;
  assign size_m1 = i_img_size - box_pkg::coord_t'(1);
  assign col_last = (col_cnt == size_m1);
  assign row_last = (row_cnt == size_m1);

  assign o_col = col_cnt;
  assign o_rows_filled = (row_cnt >= WIN - 1);
  assign o_frame_end = accept_pix & col_last & row_last;

  always_ff @(posedge clk) begin
    if (!rst_n || i_clear) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (accept_pix) begin
      if (col_last) begin
        col_cnt <= '0;
        row_cnt <= row_cnt + box_pkg::coord_t'(1);
      end else begin
        col_cnt <= col_cnt + box_pkg::coord_t'(1);
      end
    end
  end

  // Tags line up with the column register in the line window.
  always_ff @(posedge clk) begin
    if (!rst_n || i_clear) begin
      first_s0 <= 1'b0;
      sub_s0 <= 1'b0;
      tag_s0 <= 1'b0;
    end else if (accept_pix) begin
      first_s0 <= (col_cnt == '0);
      sub_s0 <= (col_cnt >= WIN);
      tag_s0 <= (col_cnt >= WIN - 1) && (row_cnt >= WIN - 1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || i_clear) begin
      v_sr <= '0;
      first_sr <= '0;
      sub_sr <= '0;
      tag_sr <= '0;
    end else begin
      v_sr <= {v_sr[3:1], i_col_valid};
      first_sr <= {first_sr[3:1], first_s0};
      sub_sr <= {sub_sr[3:1], sub_s0};
      tag_sr <= {tag_sr[3:1], tag_s0};
    end
  end

  always_comb begin
    for (int k = 0; k < WIN; k++) begin
      px[k] = i_column[k*PW +: PW];
    end
  end

  // Adder tree, four register stages.
  always_ff @(posedge clk) begin
    for (int k = 0; k < 6; k++) begin
      pair_s1[k] <= {1'b0, px[2*k]} + {1'b0, px[2*k+1]};
    end
    odd_s1 <= px[WIN-1];
    for (int k = 0; k < 3; k++) begin
      quad_s2[k] <= {1'b0, pair_s1[2*k]} + {1'b0, pair_s1[2*k+1]};
    end
    odd_s2 <= odd_s1;
    half_s3[0] <= {1'b0, quad_s2[0]} + {1'b0, quad_s2[1]};
    half_s3[1] <= {1'b0, quad_s2[2]} + {3'b000, odd_s2};
    col_s4 <= {1'b0, half_s3[0]} + {1'b0, half_s3[1]};
  end

  // History of the last 13 valid column sums.
  always_ff @(posedge clk) begin
    if (v_sr[4]) begin
      hist[0] <= col_s4;
      for (int k = 1; k < WIN; k++) begin
        hist[k] <= hist[k-1];
      end
    end
  end

  assign col_ext = box_pkg::win_sum_t'(col_s4);
  assign old_ext = sub_sr[4] ? box_pkg::win_sum_t'(hist[WIN-1]) : '0;

  // Running sum doubles as the output register.
  always_ff @(posedge clk) begin
    if (!rst_n || i_clear) begin
      acc_sum <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= v_sr[4] & tag_sr[4];
      if (v_sr[4]) begin
        acc_sum <= first_sr[4] ? col_ext : acc_sum + col_ext - old_ext;
      end
    end
  end

  assign o_sum = acc_sum;

  generate
    if (USE_CENTER != 0) begin : g_center
      box_pkg::pix_t ctr_sr [`BOX_RADIUS];
      box_pkg::pix_t ctr_d [1:4];
      box_pkg::pix_t ctr_q;

      // Centre row of each valid column, six columns deep.
      always_ff @(posedge clk) begin
        if (i_col_valid) begin
          ctr_sr[0] <= px[`BOX_RADIUS];
          for (int k = 1; k < `BOX_RADIUS; k++) begin
            ctr_sr[k] <= ctr_sr[k-1];
          end
        end
      end

      always_ff @(posedge clk) begin
        ctr_d[1] <= ctr_sr[`BOX_RADIUS-1];
        for (int k = 2; k <= 4; k++) begin
          ctr_d[k] <= ctr_d[k-1];
        end
        ctr_q <= ctr_d[4];
      end

      assign o_center = ctr_q;
    end else begin : g_no_center
      assign o_center = '0;
    end
  endgenerate

  a_col_below_size: assert property (@(posedge clk) disable iff (!rst_n)
    i_accept |-> col_cnt < i_img_size);

  // An output must come from a column tagged inside the image.
  a_valid_tagged: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid |-> $past(i_col_valid && tag_s0, 5));

endmodule

//--- design/box_ctrl.sv
`include "box_macros.svh"

module box_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic i_start,
  input  logic i_rows_filled,
  input  logic i_frame_end,
  output logic o_clear,
  output logic o_accept,
  output logic o_busy,
  output logic o_done
);

  localparam int CNT_W = $clog2(`BOX_LATENCY + 1);

  box_pkg::ctrl_state_t state;
  box_pkg::ctrl_state_t state_nxt;
  logic [CNT_W-1:0]     flush_cnt;
  logic                 flush_last;

  assign flush_last = (flush_cnt == CNT_W'(`BOX_LATENCY - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      box_pkg::IDLE: begin
        if (i_start) begin
          state_nxt = box_pkg::FILL;
        end
      end
      box_pkg::FILL: begin
        if (i_frame_end) begin
          state_nxt = box_pkg::FLUSH;
        end else if (i_rows_filled) begin
          state_nxt = box_pkg::RUN;
        end
      end
      box_pkg::RUN: begin
        if (i_frame_end) begin
          state_nxt = box_pkg::FLUSH;
        end
      end
      box_pkg::FLUSH: begin
        if (flush_last) begin
          state_nxt = box_pkg::IDLE;
        end
      end
      default: begin
        state_nxt = box_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= box_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Wait out the pipeline after the last pixel.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flush_cnt <= '0;
    end else if (state != box_pkg::FLUSH) begin
      flush_cnt <= '0;
    end else begin
      flush_cnt <= flush_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_done <= 1'b0;
    end else begin
      o_done <= (state == box_pkg::FLUSH) && flush_last;
    end
  end

  assign o_clear = (state == box_pkg::IDLE) && i_start;
  assign o_accept = (state == box_pkg::FILL) || (state == box_pkg::RUN);
  assign o_busy = (state != box_pkg::IDLE);

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    o_done |-> (state == box_pkg::IDLE) ##1 !o_done);

endmodule

//--- design/box_filter_top.sv
module box_filter_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_start,
  input  box_pkg::coord_t   i_img_size,
  input  logic              i_valid,
  input  box_pkg::pix_t     i_pixel,
  output logic              o_valid,
  output box_pkg::win_sum_t o_sum,
  output box_pkg::pix_t     o_center,
  output logic              o_busy,
  output logic              o_done
);

  logic              clear;
  logic              accept;
  logic              rows_filled;
  logic              frame_end;
  logic              col_valid;
  box_pkg::coord_t   col;
  box_pkg::col_vec_t column;

  box_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (i_start),
    .i_rows_filled (rows_filled),
    .i_frame_end   (frame_end),
    .o_clear       (clear),
    .o_accept      (accept),
    .o_busy        (o_busy),
    .o_done        (o_done)
  );

  box_line_window u_line_window (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_accept    (accept),
    .i_valid     (i_valid),
    .i_pixel     (i_pixel),
    .i_col       (col),
    .o_col_valid (col_valid),
    .o_column    (column)
  );

  box_window_sum #(
    .USE_CENTER (1)
  ) u_window_sum (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_clear       (clear),
    .i_accept      (accept),
    .i_valid       (i_valid),
    .i_img_size    (i_img_size),
    .i_col_valid   (col_valid),
    .i_column      (column),
    .o_col         (col),
    .o_rows_filled (rows_filled),
    .o_frame_end   (frame_end),
    .o_valid       (o_valid),
    .o_sum         (o_sum),
    .o_center      (o_center)
  );

endmodule

//--- test/box_filter_tb.sv
`include "box_macros.svh"

module box_filter_tb;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_FRAMES = 6;
  localparam int MAX_GAP = 3;
  localparam int IMG_CELLS = `BOX_MAX_IMG * `BOX_MAX_IMG;

  logic              clk;
  logic              rst_n;
  logic              i_start;
  box_pkg::coord_t   i_img_size;
  logic              i_valid;
  box_pkg::pix_t     i_pixel;
  logic              o_valid;
  box_pkg::win_sum_t o_sum;
  box_pkg::pix_t     o_center;
  logic              o_busy;
  logic              o_done;

  box_pkg::pix_t img [IMG_CELLS];
  int            cur_n;
  int            out_idx;
  int            done_count;
  logic          active;

  box_filter_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_start    (i_start),
    .i_img_size (i_img_size),
    .i_valid    (i_valid),
    .i_pixel    (i_pixel),
    .o_valid    (o_valid),
    .o_sum      (o_sum),
    .o_center   (o_center),
    .o_busy     (o_busy),
    .o_done     (o_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Frame list.
  function automatic int image_side(input int f);
    case (f)
      0: return 16;
      1: return 20;
      2: return 14;
      3: return 14;
      4: return 13;
      default: return 64;
    endcase
  endfunction

  // 0 random, 1 all ones, 2 all zeros.
  function automatic int fill_mode(input int f);
    case (f)
      2: return 1;
      3: return 2;
      default: return 0;
    endcase
  endfunction

  function automatic bit has_gaps(input int f);
    return (f == 1);
  endfunction

  // Sum and centre of the window whose top-left corner is (wr, wc).
  function automatic logic [23:0] window_ref(input int n, input int wr, input int wc);
    int            sum;
    box_pkg::pix_t ctr;
    sum = 0;
    for (int y = 0; y < `BOX_WIN; y++) begin
      for (int x = 0; x < `BOX_WIN; x++) begin
        sum += img[(wr + y) * n + wc + x];
      end
    end
    ctr = img[(wr + `BOX_RADIUS) * n + wc + `BOX_RADIUS];
    return {sum[15:0], ctr};
  endfunction

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
      stop_on_failure("A DUT output did not match its expected value.");
    end
  endtask

  task automatic run_frame(input int f);
    int n;
    int gap;
    n = image_side(f);
    for (int k = 0; k < n * n; k++) begin
      case (fill_mode(f))
        0: img[k] = box_pkg::pix_t'($urandom % 256);
        1: img[k] = 8'hff;
        default: img[k] = 8'h00;
      endcase
    end
    cur_n = n;
    i_img_size <= box_pkg::coord_t'(n);
    // Pixels while idle must be dropped.
    repeat (3) begin
      i_valid <= 1'b1;
      i_pixel <= box_pkg::pix_t'($urandom % 256);
      @(posedge clk);
    end
    i_valid <= 1'b0;
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
    for (int k = 0; k < n * n; k++) begin
      i_valid <= 1'b1;
      i_pixel <= img[k];
      @(posedge clk);
      if (has_gaps(f)) begin
        gap = 1 + $urandom % MAX_GAP;
        repeat (gap) begin
          i_valid <= 1'b0;
          i_pixel <= box_pkg::pix_t'($urandom % 256);
          @(posedge clk);
        end
      end
    end
    // These land in FLUSH.
    repeat (3) begin
      i_valid <= 1'b1;
      i_pixel <= box_pkg::pix_t'($urandom % 256);
      @(posedge clk);
    end
    i_valid <= 1'b0;
    while (done_count <= f) begin
      @(posedge clk);
    end
  endtask

  initial begin
    void'($urandom(32'hf130));
    rst_n = 1'b0;
    i_start = 1'b0;
    i_img_size = '0;
    i_valid = 1'b0;
    i_pixel = '0;
    cur_n = `BOX_WIN;
    out_idx = 0;
    done_count = 0;
    active = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      run_frame(f);
    end
    repeat (5) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

  // Output checker, in raster order of window position.
  always @(posedge clk) begin : compare
    logic [23:0] exp_v;
    int          m;
    if (rst_n) begin
      m = cur_n - (`BOX_WIN - 1);
      if (o_valid) begin
        if (!active) begin
          stop_on_failure("o_valid went high while no frame was in progress.");
        end
        if (out_idx >= m * m) begin
          stop_on_failure($sformatf("Frame of size %0d gave more than %0d outputs.",
                                    cur_n, m * m));
        end
        exp_v = window_ref(cur_n, out_idx / m, out_idx % m);
        check_equal("o_sum", exp_v[23:8], o_sum);
        check_equal("o_center", exp_v[7:0], o_center);
        out_idx++;
      end
      if (o_done) begin
        if (!active) begin
          stop_on_failure("o_done pulsed while no frame was in progress.");
        end
        check_equal("o_busy", 0, o_busy);
        if (out_idx != m * m) begin
          stop_on_failure($sformatf("Frame of size %0d gave %0d outputs instead of %0d.",
                                    cur_n, out_idx, m * m));
        end
        done_count++;
        out_idx = 0;
        active = 1'b0;
      end else begin
        check_equal("o_busy", active, o_busy);
      end
      if (i_start) begin
        active = 1'b1;
      end
    end
  end

  initial begin : watchdog
    int limit;
    limit = 0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      limit += image_side(f) * image_side(f) * (MAX_GAP + 2) + 200;
    end
    #(limit * CLK_PERIOD);
    stop_on_failure($sformatf("The run timed out after %0d clock cycles.", limit));
  end

endmodule

//--- box_filter.f
+incdir+design
design/box_pkg.sv
design/box_line_window.sv
design/box_window_sum.sv
design/box_ctrl.sv
design/box_filter_top.sv
test/box_filter_tb.sv
